/* testbench/ctrl_cases.txt */
# op addr data strb expected, all hex; R data bit 0 = ap_idle, bit 1 = ap_ready during AR
# ops: W write, R read, D done pulse, Y ready pulse, I irq, S ap_start, P port_regs word
W 10 11223344 f 0
W 14 55667788 f 0
W 28 a5a5a5a5 f 0
W 34 deadbeef f 0
W 10 ffffffff 5 0
R 10 0 0 11ff33ff
P 10 0 0 11ff33ff
P 14 0 0 55667788
W 2c 0000cafe 3 0
W 2c 12345678 8 0
R 2c 0 0 1200cafe
P 2c 0 0 1200cafe
W 34 00000000 6 0
R 34 0 0 de0000ef
P 34 0 0 de0000ef
R 28 0 0 a5a5a5a5
W 3c 00000400 2 0
P 3c 0 0 00000400
R 18 0 0 00000000
S 00 0 0 0
W 00 1 1 0
S 00 0 0 1
Y 00 0 0 0
S 00 0 0 0
W 00 81 1 0
Y 00 0 0 0
S 00 0 0 1
R 00 0 0 00000081
W 00 0 1 0
Y 00 0 0 0
S 00 0 0 0
D 00 0 0 0
R 00 1 0 00000006
R 00 2 0 00000008
R 00 0 0 00000000
W 08 3 1 0
W 04 1 1 0
I 00 0 0 0
D 00 0 0 0
I 00 0 0 1
R 0c 0 0 00000001
W 0c 1 1 0
I 00 0 0 0
W 04 0 1 0
D 00 0 0 0
Y 00 0 0 0
I 00 0 0 0
R 0c 0 0 00000003
R 04 0 0 00000000
W 04 1 1 0
I 00 0 0 1
W 0c 3 1 0
I 00 0 0 0
R 00 0 0 00000002
R 00 0 0 00000000

/* list.f */
+incdir+source
source/ctrl_pkg.sv
source/axil_write_channel.sv
source/axil_read_channel.sv
source/ap_ctrl_regs.sv
source/port_pointer_regs.sv
source/ctrl_regs_top.sv
testbench/tb_ctrl_regs.sv

/* Bender.yml */
package:
  name: ctrl_regs

export_include_dirs:
  - source

sources:
  - files:
      - source/ctrl_pkg.sv
      - source/axil_write_channel.sv
      - source/axil_read_channel.sv
      - source/ap_ctrl_regs.sv
      - source/port_pointer_regs.sv
      - source/ctrl_regs_top.sv
  - target: test
    files:
      - testbench/tb_ctrl_regs.sv

/* testbench/tb_ctrl_regs.sv */
`default_nettype none

`include "ctrl_config.svh"

// testbench for the AXI4-Lite control block, driven from a case file
module tb_ctrl_regs;

  // one line of the case file
  typedef struct packed {
    logic [7:0]      op;
    ctrl_pkg::addr_t addr;
    ctrl_pkg::data_t data;
    ctrl_pkg::strb_t strb;
    ctrl_pkg::data_t expected;
  } case_t;

  logic            clk;
  logic            rst_n;
  ctrl_pkg::addr_t awaddr;
  logic            awvalid;
  logic            awready;
  ctrl_pkg::data_t wdata;
  ctrl_pkg::strb_t wstrb;
  logic            wvalid;
  logic            wready;
  logic            bvalid;
  logic            bready;
  ctrl_pkg::addr_t araddr;
  logic            arvalid;
  logic            arready;
  ctrl_pkg::data_t rdata;
  logic            rvalid;
  logic            rready;
  logic            ap_start;
  logic            ap_done;
  logic            ap_ready;
  logic            ap_idle;
  logic            irq;
  ctrl_pkg::port_regs_t [`CTRL_NUM_PORTS-1:0] port_regs;

  case_t       cases[$];
  logic        cases_loaded;
  int unsigned lcg_state;

  ctrl_regs_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .awaddr_i    (awaddr),
    .awvalid_i   (awvalid),
    .awready_o   (awready),
    .wdata_i     (wdata),
    .wstrb_i     (wstrb),
    .wvalid_i    (wvalid),
    .wready_o    (wready),
    .bvalid_o    (bvalid),
    .bready_i    (bready),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .arready_o   (arready),
    .rdata_o     (rdata),
    .rvalid_o    (rvalid),
    .rready_i    (rready),
    .ap_start_o  (ap_start),
    .ap_done_i   (ap_done),
    .ap_ready_i  (ap_ready),
    .ap_idle_i   (ap_idle),
    .irq_o       (irq),
    .port_regs_o (port_regs)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // plain 32-bit LCG
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // 0 to 3 idle cycles taken from the upper LCG bits
  task automatic idle_cycles();
    int unsigned n;
    n = (lcg_next() >> 16) % 4;
    repeat (n) @(negedge clk);
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    logic [7:0]  op;
    logic [8*256-1:0] line;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] e;
    case_t       c;
    fd = $fopen("testbench/ctrl_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file testbench/ctrl_cases.txt");
      $display("TESTS FAILED");
      $fatal(1);
    end
    n = $fscanf(fd, " %c", op);
    while (n == 1) begin
      if (op == "#") begin
        // rest of a comment line
        n = $fgets(line, fd);
      end else begin
        n = $fscanf(fd, " %h %h %h %h", a, d, s, e);
        if (n != 4) begin
          $display("case line %0d is missing fields", cases.size() + 1);
          $display("TESTS FAILED");
          $fatal(1);
        end
        c.op       = op;
        c.addr     = a[7:0];
        c.data     = d;
        c.strb     = s[3:0];
        c.expected = e;
        cases.push_back(c);
      end
      n = $fscanf(fd, " %c", op);
    end
    $fclose(fd);
  endtask

  // word of port_regs selected by its register byte offset
  function automatic ctrl_pkg::data_t port_word(input ctrl_pkg::addr_t addr);
    int                   idx;
    int                   off;
    ctrl_pkg::port_regs_t regs;
    ctrl_pkg::data_t      word;
    idx  = (int'(addr) - `CTRL_OFF_PORT_BASE) / `CTRL_PORT_STRIDE;
    off  = (int'(addr) - `CTRL_OFF_PORT_BASE) % `CTRL_PORT_STRIDE;
    regs = port_regs[idx];
    case (off)
      `CTRL_WORD_SRC_LSB: word = regs.src_addr[31:0];
      `CTRL_WORD_SRC_MSB: word = regs.src_addr[63:32];
      `CTRL_WORD_DST_LSB: word = regs.dst_addr[31:0];
      `CTRL_WORD_DST_MSB: word = regs.dst_addr[63:32];
      `CTRL_WORD_RD_LEN:  word = regs.src_size;
      `CTRL_WORD_WR_LEN:  word = regs.dst_size;
      default:            word = 'x;
    endcase
    return word;
  endfunction

  task automatic write_reg(input ctrl_pkg::addr_t addr, input ctrl_pkg::data_t data,
                           input ctrl_pkg::strb_t strb);
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    // ready seen mid-cycle means the beat goes at the next rising edge
    while (!awready) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    idle_cycles();
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    while (!wready) @(negedge clk);
    @(negedge clk);
    wvalid = 1'b0;
    idle_cycles();
    bready = 1'b1;
    while (!bvalid) @(negedge clk);
    @(negedge clk);
    bready = 1'b0;
    // exactly one response per write
    check_value("bvalid_o", 32'h0, bvalid);
  endtask

  // levels bit 0 is ap_idle, bit 1 is ap_ready, held for the AR beat only
  task automatic read_reg(input ctrl_pkg::addr_t addr, input logic [1:0] levels,
                          output ctrl_pkg::data_t value);
    @(negedge clk);
    araddr   = addr;
    arvalid  = 1'b1;
    ap_idle  = levels[0];
    ap_ready = levels[1];
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid  = 1'b0;
    ap_idle  = 1'b0;
    ap_ready = 1'b0;
    idle_cycles();
    rready = 1'b1;
    while (!rvalid) @(negedge clk);
    value = rdata;
    @(negedge clk);
    rready = 1'b0;
    check_value("rvalid_o", 32'h0, rvalid);
  endtask

  // hang guard sized from the number of case lines
  initial begin
    wait (cases_loaded);
    repeat (8 + cases.size() * 40) @(posedge clk);
    $display("the run timed out before all %0d cases completed", cases.size());
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial begin
    case_t           c;
    ctrl_pkg::data_t value;
    rst_n        = 1'b0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    ap_done      = 1'b0;
    ap_ready     = 1'b0;
    ap_idle      = 1'b0;
    lcg_state    = 29;
    cases_loaded = 1'b0;
    load_cases();
    cases_loaded = 1'b1;

    repeat (4) @(negedge clk);
    // state straight out of reset
    check_value("awready_o", 32'h1, awready);
    check_value("arready_o", 32'h1, arready);
    check_value("wready_o", 32'h0, wready);
    check_value("bvalid_o", 32'h0, bvalid);
    check_value("rvalid_o", 32'h0, rvalid);
    check_value("ap_start_o", 32'h0, ap_start);
    check_value("irq_o", 32'h0, irq);
    rst_n = 1'b1;

    for (int i = 0; i < cases.size(); i++) begin
      c = cases[i];
      case (c.op)
        "W": write_reg(c.addr, c.data, c.strb);
        "R": begin
          read_reg(c.addr, c.data[1:0], value);
          check_value("rdata_o", c.expected, value);
        end
        // one-cycle kernel pulses
        "D": begin
          @(negedge clk);
          ap_done = 1'b1;
          @(negedge clk);
          ap_done = 1'b0;
        end
        "Y": begin
          @(negedge clk);
          ap_ready = 1'b1;
          @(negedge clk);
          ap_ready = 1'b0;
        end
        "I": begin
          @(negedge clk);
          check_value("irq_o", c.expected, irq);
        end
        "S": begin
          @(negedge clk);
          check_value("ap_start_o", c.expected, ap_start);
        end
        "P": begin
          @(negedge clk);
          check_value("port_regs_o", c.expected, port_word(c.addr));
        end
        default: begin
          $display("unknown opcode %c on case line %0d", c.op, i + 1);
          $display("TESTS FAILED");
          $fatal(1);
        end
      endcase
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* source/ctrl_regs_top.sv */
`default_nettype none

`include "ctrl_config.svh"

// control and status block of the kernel, seen from the host as AXI4-Lite
module ctrl_regs_top (
  input  wire                                             clk,
  input  wire                                             rst_n,
  input  wire ctrl_pkg::addr_t                            awaddr_i,
  input  wire                                             awvalid_i,
  output wire                                             awready_o,
  input  wire ctrl_pkg::data_t                            wdata_i,
  input  wire ctrl_pkg::strb_t                            wstrb_i,
  input  wire                                             wvalid_i,
  output wire                                             wready_o,
  output wire                                             bvalid_o,
  input  wire                                             bready_i,
  input  wire ctrl_pkg::addr_t                            araddr_i,
  input  wire                                             arvalid_i,
  output wire                                             arready_o,
  output wire ctrl_pkg::data_t                            rdata_o,
  output wire                                             rvalid_o,
  input  wire                                             rready_i,
  output wire                                             ap_start_o,
  input  wire                                             ap_done_i,
  input  wire                                             ap_ready_i,
  input  wire                                             ap_idle_i,
  output wire                                             irq_o,
  output wire ctrl_pkg::port_regs_t [`CTRL_NUM_PORTS-1:0] port_regs_o
);

  // requests fan out to both register files
  wire ctrl_pkg::reg_wr_t wr_req;
  wire ctrl_pkg::reg_rd_t rd_req;
  // per-file read words, merged in the read channel
  wire ctrl_pkg::data_t   ctrl_rdata;
  wire ctrl_pkg::data_t   port_rdata;

  axil_write_channel u_wr_ch (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .wr_req_o  (wr_req)
  );

  axil_read_channel u_rd_ch (
    .clk          (clk),
    .rst_n        (rst_n),
    .araddr_i     (araddr_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .rd_req_o     (rd_req),
    .ctrl_rdata_i (ctrl_rdata),
    .port_rdata_i (port_rdata)
  );

  ap_ctrl_regs u_ap_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_req_i   (wr_req),
    .rd_req_i   (rd_req),
    .rdata_o    (ctrl_rdata),
    .ap_start_o (ap_start_o),
    .ap_done_i  (ap_done_i),
    .ap_ready_i (ap_ready_i),
    .ap_idle_i  (ap_idle_i),
    .irq_o      (irq_o)
  );

  port_pointer_regs #(
    .NUM_PORTS (`CTRL_NUM_PORTS)
  ) u_ports (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_req_i    (wr_req),
    .rd_req_i    (rd_req),
    .rdata_o     (port_rdata),
    .port_regs_o (port_regs_o)
  );

endmodule

`default_nettype wire

/* source/port_pointer_regs.sv */
`default_nettype none

`include "ctrl_config.svh"

// source and destination pointers plus lengths, one set per memory port
module port_pointer_regs #(
  parameter int NUM_PORTS = `CTRL_NUM_PORTS
) (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  wire ctrl_pkg::reg_wr_t                   wr_req_i,
  input  wire ctrl_pkg::reg_rd_t                   rd_req_i,
  output ctrl_pkg::data_t                          rdata_o,
  output wire ctrl_pkg::port_regs_t [NUM_PORTS-1:0] port_regs_o
);

  wire ctrl_pkg::data_t port_rdata [NUM_PORTS];

  // take the enabled byte lanes from the new word, keep the rest
  function automatic ctrl_pkg::data_t merge_bytes(input ctrl_pkg::data_t old_word,
                                                  input ctrl_pkg::data_t new_word,
                                                  input ctrl_pkg::strb_t strb);
    ctrl_pkg::data_t result;
    result = old_word;
    for (int b = 0; b < `CTRL_DATA_W / 8; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    localparam ctrl_pkg::addr_t PORT_BASE =
      ctrl_pkg::addr_t'(`CTRL_OFF_PORT_BASE + p * `CTRL_PORT_STRIDE);

    ctrl_pkg::port_regs_t regs_q;
    ctrl_pkg::addr_t      wr_off;
    ctrl_pkg::addr_t      rd_off;
    logic                 wr_hit;
    logic                 rd_hit;

    // offset relative to this port, only meaningful inside its window
    assign wr_off = wr_req_i.addr - PORT_BASE;
    assign rd_off = rd_req_i.addr - PORT_BASE;
    assign wr_hit = wr_req_i.valid && (wr_req_i.addr >= PORT_BASE) &&
                    (wr_off < `CTRL_PORT_STRIDE);
    assign rd_hit = rd_req_i.valid && (rd_req_i.addr >= PORT_BASE) &&
                    (rd_off < `CTRL_PORT_STRIDE);

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        regs_q <= '0;
      end else if (wr_hit) begin
        case (wr_off)
          `CTRL_WORD_SRC_LSB: regs_q.src_addr[31:0] <=
            merge_bytes(regs_q.src_addr[31:0], wr_req_i.data, wr_req_i.strb);
          `CTRL_WORD_SRC_MSB: regs_q.src_addr[63:32] <=
            merge_bytes(regs_q.src_addr[63:32], wr_req_i.data, wr_req_i.strb);
          `CTRL_WORD_DST_LSB: regs_q.dst_addr[31:0] <=
            merge_bytes(regs_q.dst_addr[31:0], wr_req_i.data, wr_req_i.strb);
          `CTRL_WORD_DST_MSB: regs_q.dst_addr[63:32] <=
            merge_bytes(regs_q.dst_addr[63:32], wr_req_i.data, wr_req_i.strb);
          `CTRL_WORD_RD_LEN: regs_q.src_size <=
            merge_bytes(regs_q.src_size, wr_req_i.data, wr_req_i.strb);
          `CTRL_WORD_WR_LEN: regs_q.dst_size <=
            merge_bytes(regs_q.dst_size, wr_req_i.data, wr_req_i.strb);
          default: regs_q <= regs_q;
        endcase
      end
    end

    assign port_rdata[p] = !rd_hit ? '0 :
                           (rd_off == `CTRL_WORD_SRC_LSB) ? regs_q.src_addr[31:0] :
                           (rd_off == `CTRL_WORD_SRC_MSB) ? regs_q.src_addr[63:32] :
                           (rd_off == `CTRL_WORD_DST_LSB) ? regs_q.dst_addr[31:0] :
                           (rd_off == `CTRL_WORD_DST_MSB) ? regs_q.dst_addr[63:32] :
                           (rd_off == `CTRL_WORD_RD_LEN)  ? regs_q.src_size :
                           (rd_off == `CTRL_WORD_WR_LEN)  ? regs_q.dst_size : '0;

    assign port_regs_o[p] = regs_q;
  end

  // at most one port hits, so OR-ing the words selects it
  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      rdata_o = rdata_o | port_rdata[i];
    end
  end

endmodule

`default_nettype wire

/* source/ap_ctrl_regs.sv */
`default_nettype none

`include "ctrl_config.svh"

// kernel handshake word and interrupt registers
module ap_ctrl_regs (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire ctrl_pkg::reg_wr_t wr_req_i,
  input  wire ctrl_pkg::reg_rd_t rd_req_i,
  output ctrl_pkg::data_t       rdata_o,
  output logic                  ap_start_o,
  input  wire                   ap_done_i,
  input  wire                   ap_ready_i,
  input  wire                   ap_idle_i,
  output logic                  irq_o
);

  logic       start_q;
  logic       done_q;
  logic       auto_restart_q;
  logic       gie_q;
  logic [1:0] ier_q;
  logic [1:0] isr_q;
  logic [1:0] isr_set;
  logic       wr_lane0;
  logic       wr_ctrl;
  logic       wr_gie;
  logic       wr_ier;
  logic       wr_isr;
  logic       rd_ctrl;

  // all control bits live in byte lane 0
  assign wr_lane0 = wr_req_i.valid && wr_req_i.strb[0];
  assign wr_ctrl  = wr_lane0 && (wr_req_i.addr == `CTRL_OFF_AP_CTRL);
  assign wr_gie   = wr_lane0 && (wr_req_i.addr == `CTRL_OFF_GIE);
  assign wr_ier   = wr_lane0 && (wr_req_i.addr == `CTRL_OFF_IER);
  assign wr_isr   = wr_lane0 && (wr_req_i.addr == `CTRL_OFF_ISR);
  assign rd_ctrl  = rd_req_i.valid && (rd_req_i.addr == `CTRL_OFF_AP_CTRL);

  // channel 0 is done, channel 1 is ready
  assign isr_set = {ier_q[1] && ap_ready_i, ier_q[0] && ap_done_i};

  assign ap_start_o = start_q;
  assign irq_o      = gie_q && (|isr_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_q        <= 1'b0;
      done_q         <= 1'b0;
      auto_restart_q <= 1'b0;
      gie_q          <= 1'b0;
      ier_q          <= 2'b00;
      isr_q          <= 2'b00;
    end else begin
      // start clears on the ready handshake unless auto-restart is on
      if (wr_ctrl && wr_req_i.data[0]) begin
        start_q <= 1'b1;
      end else if (ap_ready_i) begin
        start_q <= auto_restart_q;
      end
      // done is sticky until the host reads the control word
      if (ap_done_i) begin
        done_q <= 1'b1;
      end else if (rd_ctrl) begin
        done_q <= 1'b0;
      end
      if (wr_ctrl) begin
        auto_restart_q <= wr_req_i.data[`CTRL_BIT_AUTO_RESTART];
      end
      if (wr_gie) begin
        gie_q <= wr_req_i.data[0];
      end
      if (wr_ier) begin
        ier_q <= wr_req_i.data[1:0];
      end
      // a kernel event wins over a host toggle on the same bit
      if (wr_isr) begin
        isr_q <= isr_set | (isr_q ^ wr_req_i.data[1:0]);
      end else begin
        isr_q <= isr_set | isr_q;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (rd_req_i.valid) begin
      case (rd_req_i.addr)
        `CTRL_OFF_AP_CTRL: begin
          // idle and ready are passed straight from the kernel
          rdata_o[0] = start_q;
          rdata_o[1] = done_q;
          rdata_o[2] = ap_idle_i;
          rdata_o[3] = ap_ready_i;
          rdata_o[`CTRL_BIT_AUTO_RESTART] = auto_restart_q;
        end
        `CTRL_OFF_GIE: rdata_o[0] = gie_q;
        `CTRL_OFF_IER: rdata_o[1:0] = ier_q;
        `CTRL_OFF_ISR: rdata_o[1:0] = isr_q;
        default: rdata_o = '0;
      endcase
    end
  end

  // no interrupt leaves the block with the global enable off
  a_irq_needs_gie: assert property (
    @(posedge clk) disable iff (!rst_n) irq_o |-> gie_q
  );

endmodule

`default_nettype wire

/* source/axil_read_channel.sv */
`default_nettype none

// read path of the slave
// strobe the register files on AR, return the merged word one cycle later
module axil_read_channel (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire ctrl_pkg::addr_t araddr_i,
  input  wire                 arvalid_i,
  output logic                arready_o,
  output ctrl_pkg::data_t     rdata_o,
  output logic                rvalid_o,
  input  wire                 rready_i,
  output ctrl_pkg::reg_rd_t   rd_req_o,
  input  wire ctrl_pkg::data_t ctrl_rdata_i,
  input  wire ctrl_pkg::data_t port_rdata_i
);

  ctrl_pkg::rd_state_e state_q;
  ctrl_pkg::rd_state_e state_d;
  ctrl_pkg::data_t     rdata_q;
  logic                ar_hs;

  assign arready_o = (state_q == ctrl_pkg::RD_IDLE);
  assign rvalid_o  = (state_q == ctrl_pkg::RD_DATA);
  assign rdata_o   = rdata_q;

  assign ar_hs = arvalid_i && arready_o;

  // strobe lasts only the AR handshake cycle
  assign rd_req_o = '{valid: ar_hs, addr: araddr_i};

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_pkg::RD_IDLE: begin
        if (ar_hs) begin
          state_d = ctrl_pkg::RD_DATA;
        end
      end
      ctrl_pkg::RD_DATA: begin
        if (rready_i) begin
          state_d = ctrl_pkg::RD_IDLE;
        end
      end
      default: state_d = ctrl_pkg::RD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ctrl_pkg::RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // each file drives zero outside its own range so an OR merges them
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_q <= ctrl_rdata_i | port_rdata_i;
    end
  end

  // read data must not move while the master stalls
  a_rdata_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o)
  );

endmodule

`default_nettype wire

/* source/axil_write_channel.sv */
`default_nettype none

// write path of the slave
// address first, then data, then response, one transaction at a time
module axil_write_channel (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire ctrl_pkg::addr_t awaddr_i,
  input  wire                 awvalid_i,
  output logic                awready_o,
  input  wire ctrl_pkg::data_t wdata_i,
  input  wire ctrl_pkg::strb_t wstrb_i,
  input  wire                 wvalid_i,
  output logic                wready_o,
  output logic                bvalid_o,
  input  wire                 bready_i,
  output ctrl_pkg::reg_wr_t   wr_req_o
);

  ctrl_pkg::wr_state_e state_q;
  ctrl_pkg::wr_state_e state_d;
  // address held from the AW beat until the W beat
  ctrl_pkg::addr_t     waddr_q;
  logic                aw_hs;
  logic                w_hs;

  assign awready_o = (state_q == ctrl_pkg::WR_IDLE);
  assign wready_o  = (state_q == ctrl_pkg::WR_DATA);
  assign bvalid_o  = (state_q == ctrl_pkg::WR_RESP);

  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;

  // the register files see the data beat directly, for this one cycle
  assign wr_req_o = '{valid: w_hs, addr: waddr_q, data: wdata_i, strb: wstrb_i};

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_pkg::WR_IDLE: begin
        if (aw_hs) begin
          state_d = ctrl_pkg::WR_DATA;
        end
      end
      ctrl_pkg::WR_DATA: begin
        if (w_hs) begin
          state_d = ctrl_pkg::WR_RESP;
        end
      end
      // response held here until the master takes it
      ctrl_pkg::WR_RESP: begin
        if (bready_i) begin
          state_d = ctrl_pkg::WR_IDLE;
        end
      end
      default: state_d = ctrl_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ctrl_pkg::WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      waddr_q <= awaddr_i;
    end
  end

  // address and data phases never overlap
  a_aw_w_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(awready_o && wready_o)
  );

endmodule

`default_nettype wire

/* source/ctrl_pkg.sv */
`default_nettype none

`include "ctrl_config.svh"

package ctrl_pkg;

  // byte offset into the register map
  typedef logic [`CTRL_ADDR_W-1:0] addr_t;
  // one register word
  typedef logic [`CTRL_DATA_W-1:0] data_t;
  // one strobe per byte lane
  typedef logic [`CTRL_DATA_W/8-1:0] strb_t;
  // 64-bit memory pointer, made of two words
  typedef logic [2*`CTRL_DATA_W-1:0] ptr_t;

  // everything one memory port needs from the host
  typedef struct packed {
    ptr_t  src_addr;
    ptr_t  dst_addr;
    data_t src_size;
    data_t dst_size;
  } port_regs_t;

  // single-cycle register write
  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
    strb_t strb;
  } reg_wr_t;

  // single-cycle register read strobe
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } reg_rd_t;

  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_DATA = 2'd1,
    WR_RESP = 2'd2
  } wr_state_e;

  typedef enum logic [0:0] {
    RD_IDLE = 1'b0,
    RD_DATA = 1'b1
  } rd_state_e;

endpackage

`default_nettype wire

/* source/ctrl_config.svh */
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// bus widths
`define CTRL_ADDR_W 8
`define CTRL_DATA_W 32

// memory ports served by the pointer block
`define CTRL_NUM_PORTS 2

// fixed kernel control words
`define CTRL_OFF_AP_CTRL 8'h00
`define CTRL_OFF_GIE 8'h04
`define CTRL_OFF_IER 8'h08
`define CTRL_OFF_ISR 8'h0C

// first port starts here, each further port one stride up
`define CTRL_OFF_PORT_BASE 8'h10
`define CTRL_PORT_STRIDE 8'h18

// word offsets inside one port
`define CTRL_WORD_SRC_LSB 8'h00
`define CTRL_WORD_SRC_MSB 8'h04
`define CTRL_WORD_DST_LSB 8'h08
`define CTRL_WORD_DST_MSB 8'h0C
`define CTRL_WORD_RD_LEN 8'h10
`define CTRL_WORD_WR_LEN 8'h14

// auto-restart sits in the upper half of the first control byte
`define CTRL_BIT_AUTO_RESTART 7

`endif
